//--- design/manycore_pkg.sv
/*
  Shared sizes for the manycore tile array and host port,
  the host operation code and the virtual LED pattern
*/

package manycore_pkg;

  // ----------------------------------------
  // Tile array
  // ----------------------------------------
  localparam int num_tiles_lp       = 4;
  localparam int tile_id_width_lp   = 2;

  // Data memory inside each tile
  localparam int dmem_words_lp      = 256;
  localparam int dmem_addr_width_lp = 8;
  localparam int data_width_lp      = 32;

  // ----------------------------------------
  // Shell status
  // ----------------------------------------
  localparam int status_width_lp    = 16;

  // Shown on the virtual LEDs once out of reset
  localparam logic [status_width_lp-1:0] vled_pattern_lp = 16'hbeef;

  // ----------------------------------------
  // Host operations
  // ----------------------------------------
  // Only READ and ADD return a response to the host
  typedef enum logic [1:0] {
    MC_OP_WRITE = 2'd0,
    MC_OP_READ  = 2'd1,
    MC_OP_ADD   = 2'd2
  } mc_op_e;

endpackage

//--- design/host_link.sv
/*
  Host request feeder
  Registers each host request and steers it to a single tile
  through a one-hot strobe, with the fields shared by all tiles
*/

module host_link (
  input  logic                                     clk_main_a0,
  input  logic                                     rst_main_n_sync,

  // Host request strobe, no back-pressure
  input  logic                                     host_req_v_i,
  input  manycore_pkg::mc_op_e                     host_req_op_i,
  input  logic [manycore_pkg::tile_id_width_lp-1:0]   host_req_tile_i,
  input  logic [manycore_pkg::dmem_addr_width_lp-1:0] host_req_addr_i,
  input  logic [manycore_pkg::data_width_lp-1:0]      host_req_data_i,

  // Toward the tiles
  output logic [manycore_pkg::num_tiles_lp-1:0]       tile_v_o,
  output manycore_pkg::mc_op_e                     tile_op_o,
  output logic [manycore_pkg::dmem_addr_width_lp-1:0] tile_addr_o,
  output logic [manycore_pkg::data_width_lp-1:0]      tile_data_o
);

  import manycore_pkg::*;

  logic                          req_v_q;
  mc_op_e                        req_op_q;
  logic [tile_id_width_lp-1:0]   req_tile_q;
  logic [dmem_addr_width_lp-1:0] req_addr_q;
  logic [data_width_lp-1:0]      req_data_q;

  logic [num_tiles_lp-1:0]       tile_v_n;
  logic [num_tiles_lp-1:0]       tile_v_q;
  mc_op_e                        op_q;
  logic [dmem_addr_width_lp-1:0] addr_q;
  logic [data_width_lp-1:0]      data_q;

  // ----------------------------------------
  // Host request register
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      req_v_q <= 1'b0;
    end else begin
      req_v_q <= host_req_v_i;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (host_req_v_i) begin
      req_op_q   <= host_req_op_i;
      req_tile_q <= host_req_tile_i;
      req_addr_q <= host_req_addr_i;
      req_data_q <= host_req_data_i;
    end
  end

  // ----------------------------------------
  // Tile select decode
  // ----------------------------------------
  always_comb begin
    tile_v_n = '0;
    tile_v_n[req_tile_q] = req_v_q;
  end

  // One-hot strobe register
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tile_v_q <= '0;
    end else begin
      tile_v_q <= tile_v_n;
    end
  end

  // Request fields, only meaningful under the strobe
  always_ff @(posedge clk_main_a0) begin
    if (req_v_q) begin
      op_q   <= req_op_q;
      addr_q <= req_addr_q;
      data_q <= req_data_q;
    end
  end

  // ----------------------------------------
  // Outputs
  // ----------------------------------------
  assign tile_v_o    = tile_v_q;
  assign tile_op_o   = op_q;
  assign tile_addr_o = addr_q;
  assign tile_data_o = data_q;

endmodule

//--- design/mc_tile.sv
/*
  One manycore tile with its data memory
  Write, read and atomic add complete in a single cycle,
  returning the old word for read and add
*/

module mc_tile (
  input  logic                                        clk_main_a0,
  input  logic                                        rst_main_n_sync,

  // Request from the host link
  input  logic                                        tile_v_i,
  input  manycore_pkg::mc_op_e                        tile_op_i,
  input  logic [manycore_pkg::dmem_addr_width_lp-1:0] tile_addr_i,
  input  logic [manycore_pkg::data_width_lp-1:0]      tile_data_i,

  // Response toward the collector
  output logic                                        resp_v_o,
  output logic [manycore_pkg::data_width_lp-1:0]      resp_data_o
);

  import manycore_pkg::*;

  logic [data_width_lp-1:0] dmem_r [dmem_words_lp];
  logic [data_width_lp-1:0] old_word;
  logic                     wr_en;
  logic [data_width_lp-1:0] wr_data;
  logic                     resp_v_q;
  logic [data_width_lp-1:0] resp_data_q;

  // ----------------------------------------
  // Read-modify-write datapath
  // ----------------------------------------
  // Asynchronous read so the add sees the word of the previous cycle
  assign old_word = dmem_r[tile_addr_i];

  always_comb begin
    wr_en   = 1'b0;
    wr_data = tile_data_i;
    if (tile_v_i) begin
      case (tile_op_i)
        MC_OP_WRITE: wr_en = 1'b1;
        MC_OP_ADD: begin
          wr_en   = 1'b1;
          wr_data = old_word + tile_data_i;
        end
        default: wr_en = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (wr_en) begin
      dmem_r[tile_addr_i] <= wr_data;
    end
  end

  // ----------------------------------------
  // Response register
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      resp_v_q <= 1'b0;
    end else begin
      resp_v_q <= tile_v_i && (tile_op_i == MC_OP_READ || tile_op_i == MC_OP_ADD);
    end
  end

  // Old word, also for add
  always_ff @(posedge clk_main_a0) begin
    if (tile_v_i) begin
      resp_data_q <= old_word;
    end
  end

  assign resp_v_o    = resp_v_q;
  assign resp_data_o = resp_data_q;

endmodule

//--- design/resp_collector.sv
/*
  Response collector
  Picks the single responding tile, muxes its word and
  registers the response fields for the host
*/

module resp_collector (
  input  logic                                       clk_main_a0,
  input  logic                                       rst_main_n_sync,

  input  logic [manycore_pkg::num_tiles_lp-1:0]      resp_v_i,
  input  logic [manycore_pkg::num_tiles_lp-1:0][manycore_pkg::data_width_lp-1:0] resp_data_i,

  output logic                                       host_resp_v_o,
  output logic [manycore_pkg::tile_id_width_lp-1:0]  host_resp_tile_o,
  output logic [manycore_pkg::data_width_lp-1:0]     host_resp_data_o
);

  import manycore_pkg::*;

  logic [tile_id_width_lp-1:0] sel_tile;
  logic [data_width_lp-1:0]    sel_data;

  // At most one bit set, tile latency is fixed
  always_comb begin
    sel_tile = '0;
    sel_data = '0;
    for (int i = 0; i < num_tiles_lp; i++) begin
      if (resp_v_i[i]) begin
        sel_tile = tile_id_width_lp'(i);
        sel_data = resp_data_i[i];
      end
    end
  end

  // ----------------------------------------
  // Host response register
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      host_resp_v_o <= 1'b0;
    end else begin
      host_resp_v_o <= |resp_v_i;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (|resp_v_i) begin
      host_resp_tile_o <= sel_tile;
      host_resp_data_o <= sel_data;
    end
  end

endmodule

//--- design/status_regs.sv
/*
  Shell status block
  Two-flop synchronizer for the virtual DIP switches and
  the virtual LED register
*/

module status_regs (
  input  logic                                     clk_main_a0,
  input  logic                                     rst_main_n_sync,

  input  logic [manycore_pkg::status_width_lp-1:0] vdip_i,
  output logic [manycore_pkg::status_width_lp-1:0] vdip_o,
  output logic [manycore_pkg::status_width_lp-1:0] vled_o
);

  import manycore_pkg::*;

  logic [status_width_lp-1:0] vdip_q;
  logic [status_width_lp-1:0] vdip_q2;
  logic [status_width_lp-1:0] vled_q;
  logic [status_width_lp-1:0] vled_out_q;

  // ----------------------------------------
  // DIP switch synchronizer
  // ----------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q  <= '0;
      vdip_q2 <= '0;
    end else begin
      vdip_q  <= vdip_i;
      vdip_q2 <= vdip_q;
    end
  end

  // ----------------------------------------
  // Virtual LEDs
  // ----------------------------------------
  // Pattern loads one cycle after release, output flop adds one more
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_q     <= '0;
      vled_out_q <= '0;
    end else begin
      vled_q     <= vled_pattern_lp;
      vled_out_q <= vled_q;
    end
  end

  assign vdip_o = vdip_q2;
  assign vled_o = vled_out_q;

endmodule

//--- design/manycore_top.sv
/*
  Manycore top level
  Host link, tile array in a generate loop, response collector
  and shell status block
*/

module manycore_top (
  input  logic                                        clk_main_a0,
  input  logic                                        rst_main_n_sync,

  // Host request
  input  logic                                        host_req_v_i,
  input  manycore_pkg::mc_op_e                        host_req_op_i,
  input  logic [manycore_pkg::tile_id_width_lp-1:0]   host_req_tile_i,
  input  logic [manycore_pkg::dmem_addr_width_lp-1:0] host_req_addr_i,
  input  logic [manycore_pkg::data_width_lp-1:0]      host_req_data_i,

  // Host response
  output logic                                        host_resp_v_o,
  output logic [manycore_pkg::tile_id_width_lp-1:0]   host_resp_tile_o,
  output logic [manycore_pkg::data_width_lp-1:0]      host_resp_data_o,

  // Shell status
  input  logic [manycore_pkg::status_width_lp-1:0]    vdip_i,
  output logic [manycore_pkg::status_width_lp-1:0]    vdip_o,
  output logic [manycore_pkg::status_width_lp-1:0]    vled_o
);

  import manycore_pkg::*;

  // ----------------------------------------
  // Wires
  // ----------------------------------------
  logic [num_tiles_lp-1:0]                    tile_v;
  mc_op_e                                     tile_op;
  logic [dmem_addr_width_lp-1:0]              tile_addr;
  logic [data_width_lp-1:0]                   tile_data;

  logic [num_tiles_lp-1:0]                    resp_v;
  logic [num_tiles_lp-1:0][data_width_lp-1:0] resp_data;

  // ----------------------------------------
  // Request path
  // ----------------------------------------
  host_link i_host_link (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .host_req_v_i    (host_req_v_i),
    .host_req_op_i   (host_req_op_i),
    .host_req_tile_i (host_req_tile_i),
    .host_req_addr_i (host_req_addr_i),
    .host_req_data_i (host_req_data_i),
    .tile_v_o        (tile_v),
    .tile_op_o       (tile_op),
    .tile_addr_o     (tile_addr),
    .tile_data_o     (tile_data)
  );

  // Tile array, each tile sees the shared fields and its own strobe
  for (genvar i = 0; i < num_tiles_lp; i++) begin : g_tile
    mc_tile i_mc_tile (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .tile_v_i        (tile_v[i]),
      .tile_op_i       (tile_op),
      .tile_addr_i     (tile_addr),
      .tile_data_i     (tile_data),
      .resp_v_o        (resp_v[i]),
      .resp_data_o     (resp_data[i])
    );
  end

  // ----------------------------------------
  // Response path
  // ----------------------------------------
  resp_collector i_resp_collector (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .resp_v_i         (resp_v),
    .resp_data_i      (resp_data),
    .host_resp_v_o    (host_resp_v_o),
    .host_resp_tile_o (host_resp_tile_o),
    .host_resp_data_o (host_resp_data_o)
  );

  // ----------------------------------------
  // Shell status
  // ----------------------------------------
  status_regs i_status_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .vdip_i          (vdip_i),
    .vdip_o          (vdip_o),
    .vled_o          (vled_o)
  );

endmodule

//--- tests/tb_tasks.svh
/*
  Testbench helpers and directed tests for the manycore top level
  LFSR stimulus, clock stepping, error reporting, the reference
  memory model and one task per checked behavior
*/

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ----------------------------------------
// Stimulus and model state
// ----------------------------------------
logic [15:0]                   lfsr_q = lfsr_seed_lp;
logic [data_width_lp-1:0]      ref_mem [num_tiles_lp][dmem_words_lp];
// Locations written so far, reused by the read tests
logic [tile_id_width_lp-1:0]   wr_tile_q [$];
logic [dmem_addr_width_lp-1:0] wr_addr_q [$];

// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_bit();
  logic fb;
  fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  lfsr_q = {lfsr_q[14:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r = {r[30:0], lfsr_bit()};
  end
  return r;
endfunction

// Advance to the drive point of the next cycle
task automatic step();
  @(posedge clk_main_a0);
  #drive_delay_lp;
endtask

// ----------------------------------------
// Error reporting
// ----------------------------------------
task automatic stop_on_error();
  $display("SOME TESTS FAILED");
  $fatal(1, "stopped at the first error");
endtask

task automatic fail_value(string test, logic [31:0] exp, logic [31:0] act);
  $display("Error: %s expected %0h actual %0h", test, exp, act);
  stop_on_error();
endtask

task automatic fail_note(string test, string what);
  $display("%s: %s", test, what);
  stop_on_error();
endtask

// ----------------------------------------
// Host port and reference model
// ----------------------------------------
task automatic drive_req(mc_op_e op, logic [tile_id_width_lp-1:0] tile,
                         logic [dmem_addr_width_lp-1:0] addr, logic [data_width_lp-1:0] data);
  host_req_v_i    = 1'b1;
  host_req_op_i   = op;
  host_req_tile_i = tile;
  host_req_addr_i = addr;
  host_req_data_i = data;
endtask

task automatic drive_idle();
  host_req_v_i = 1'b0;
endtask

// Returns the old word and applies the operation to the model
function automatic logic [31:0] model_access(mc_op_e op, logic [tile_id_width_lp-1:0] tile,
                                             logic [dmem_addr_width_lp-1:0] addr,
                                             logic [data_width_lp-1:0] data);
  logic [31:0] old;
  old = ref_mem[tile][addr];
  case (op)
    MC_OP_WRITE: ref_mem[tile][addr] = data;
    MC_OP_ADD:   ref_mem[tile][addr] = old + data;
    default:     ;
  endcase
  return old;
endfunction

// Edges counted from the sampling edge of the request
task automatic wait_resp(string test, output int latency);
  latency = 0;
  while (host_resp_v_o !== 1'b1) begin
    if (latency >= timeout_cycles_lp) begin
      fail_note(test, "no host response arrived before the timeout");
    end
    step();
    latency++;
  end
endtask

task automatic check_quiet(string test, int cycles);
  for (int c = 0; c < cycles; c++) begin
    step();
    assert (host_resp_v_o == 1'b0)
      else fail_note(test, "host response seen where none was requested");
  end
endtask

// One request on an idle port, response checked for value and latency
task automatic single_access(string test, mc_op_e op, logic [tile_id_width_lp-1:0] tile,
                             logic [dmem_addr_width_lp-1:0] addr,
                             logic [data_width_lp-1:0] data);
  logic [31:0] exp;
  int          latency;
  exp = model_access(op, tile, addr, data);
  drive_req(op, tile, addr, data);
  step();
  drive_idle();
  wait_resp(test, latency);
  assert (latency == resp_latency_lp)
    else fail_value(test, 32'(resp_latency_lp), 32'(latency));
  assert (host_resp_tile_o == tile)
    else fail_value(test, 32'(tile), 32'(host_resp_tile_o));
  assert (host_resp_data_o == exp)
    else fail_value(test, exp, host_resp_data_o);
  step();
  assert (host_resp_v_o == 1'b0)
    else fail_note(test, "host response valid held longer than one cycle");
endtask

// ----------------------------------------
// Directed tests
// ----------------------------------------
task automatic check_reset_state();
  int n;
  rst_main_n_sync = 1'b0;
  for (int c = 0; c < reset_cycles_lp; c++) begin
    step();
    assert (host_resp_v_o == 1'b0)
      else fail_note("reset_state", "host response valid during reset");
    assert (vled_o == '0)
      else fail_value("reset_state", 32'h0, 32'(vled_o));
  end
  rst_main_n_sync = 1'b1;
  step();
  n = 0;
  while (vled_o != vled_pattern_lp) begin
    if (n >= 2) begin
      fail_value("reset_state", 32'(vled_pattern_lp), 32'(vled_o));
    end
    step();
    n++;
  end
  // Pattern must hold with the host port idle
  for (int c = 0; c < 8; c++) begin
    step();
    assert (vled_o == vled_pattern_lp)
      else fail_value("reset_state", 32'(vled_pattern_lp), 32'(vled_o));
    assert (host_resp_v_o == 1'b0)
      else fail_note("reset_state", "host response valid after reset with no request");
  end
endtask

task automatic write_read_all_tiles();
  logic [tile_id_width_lp-1:0]   tile;
  logic [dmem_addr_width_lp-1:0] addr;
  logic [data_width_lp-1:0]      data;
  for (int t = 0; t < num_tiles_lp; t++) begin
    for (int k = 0; k < writes_per_tile_lp; k++) begin
      tile = tile_id_width_lp'(t);
      addr = dmem_addr_width_lp'(rand_bits(dmem_addr_width_lp));
      data = rand_bits(data_width_lp);
      void'(model_access(MC_OP_WRITE, tile, addr, data));
      wr_tile_q.push_back(tile);
      wr_addr_q.push_back(addr);
      drive_req(MC_OP_WRITE, tile, addr, data);
      step();
    end
  end
  drive_idle();
  check_quiet("write_read", 6);
  for (int i = 0; i < wr_tile_q.size(); i++) begin
    single_access("write_read", MC_OP_READ, wr_tile_q[i], wr_addr_q[i], '0);
  end
endtask

task automatic accumulate_adds();
  logic [tile_id_width_lp-1:0]   tile;
  logic [dmem_addr_width_lp-1:0] addr;
  logic [data_width_lp-1:0]      data;
  tile = tile_id_width_lp'(rand_bits(tile_id_width_lp));
  addr = dmem_addr_width_lp'(rand_bits(dmem_addr_width_lp));
  data = rand_bits(data_width_lp);
  void'(model_access(MC_OP_WRITE, tile, addr, data));
  drive_req(MC_OP_WRITE, tile, addr, data);
  step();
  drive_idle();
  check_quiet("atomic_add", 4);
  // Full 32-bit addends, so the sum wraps
  for (int k = 0; k < add_count_lp; k++) begin
    single_access("atomic_add", MC_OP_ADD, tile, addr, rand_bits(data_width_lp));
  end
  single_access("atomic_add", MC_OP_READ, tile, addr, '0);
endtask

task automatic read_burst();
  mc_op_e                        op_q [$];
  logic [tile_id_width_lp-1:0]   tile_q [$];
  logic [dmem_addr_width_lp-1:0] addr_q [$];
  logic [data_width_lp-1:0]      data_q [$];
  int                            exp_at_q [$];
  logic [tile_id_width_lp-1:0]   exp_tile_q [$];
  logic [data_width_lp-1:0]      exp_data_q [$];
  logic [31:0]                   exp;
  int                            idx;
  int                            t;
  for (int i = 0; i < burst_len_lp; i++) begin
    idx = int'(rand_bits(5)) % wr_tile_q.size();
    op_q.push_back(MC_OP_READ);
    tile_q.push_back(wr_tile_q[idx]);
    addr_q.push_back(wr_addr_q[idx]);
    data_q.push_back('0);
  end
  // One write inside the burst, read back four slots later
  op_q[5]   = MC_OP_WRITE;
  data_q[5] = rand_bits(data_width_lp);
  tile_q[9] = tile_q[5];
  addr_q[9] = addr_q[5];
  t = 0;
  while (t < op_q.size() || exp_at_q.size() > 0) begin
    if (t >= op_q.size() + timeout_cycles_lp) begin
      fail_note("back_to_back", "responses still missing after the burst");
    end
    if (host_resp_v_o == 1'b1) begin
      if (exp_at_q.size() == 0) begin
        fail_note("back_to_back", "host response with no matching request");
      end
      assert (exp_at_q[0] == t)
        else fail_value("back_to_back", 32'(exp_at_q[0]), 32'(t));
      assert (host_resp_tile_o == exp_tile_q[0])
        else fail_value("back_to_back", 32'(exp_tile_q[0]), 32'(host_resp_tile_o));
      assert (host_resp_data_o == exp_data_q[0])
        else fail_value("back_to_back", exp_data_q[0], host_resp_data_o);
      exp_at_q.delete(0);
      exp_tile_q.delete(0);
      exp_data_q.delete(0);
    end else if (exp_at_q.size() > 0 && exp_at_q[0] == t) begin
      fail_note("back_to_back", "expected host response did not arrive on time");
    end
    if (t < op_q.size()) begin
      exp = model_access(op_q[t], tile_q[t], addr_q[t], data_q[t]);
      if (op_q[t] != MC_OP_WRITE) begin
        // Sampled at the next edge, visible three edges later
        exp_at_q.push_back(t + resp_latency_lp + 1);
        exp_tile_q.push_back(tile_q[t]);
        exp_data_q.push_back(exp);
      end
      drive_req(op_q[t], tile_q[t], addr_q[t], data_q[t]);
    end else begin
      drive_idle();
    end
    step();
    t++;
  end
  drive_idle();
endtask

task automatic dip_passthrough();
  logic [status_width_lp-1:0] val;
  int                         n;
  for (int k = 0; k < status_rounds_lp; k++) begin
    val = status_width_lp'(rand_bits(status_width_lp));
    if (val == vdip_o) begin
      val = ~val;
    end
    vdip_i = val;
    step();
    n = 1;
    while (vdip_o != val) begin
      if (n >= timeout_cycles_lp) begin
        fail_note("status", "DIP value never reached vdip_o");
      end
      step();
      n++;
    end
    assert (n == dip_latency_lp)
      else fail_value("status", 32'(dip_latency_lp), 32'(n));
    assert (vled_o == vled_pattern_lp)
      else fail_value("status", 32'(vled_pattern_lp), 32'(vled_o));
  end
endtask

`endif

//--- tests/tb_manycore_top.sv
/*
  Testbench for the manycore top level
  Clock, reset, DUT instance and the directed test sequence
*/

module tb_manycore_top;

  import manycore_pkg::*;

  // ----------------------------------------
  // Testbench constants
  // ----------------------------------------
  localparam int          clk_period_lp      = 20;
  localparam int          drive_delay_lp     = 2;
  localparam int          reset_cycles_lp    = 16;
  localparam int          timeout_cycles_lp  = 20;
  localparam int          resp_latency_lp    = 3;
  localparam int          dip_latency_lp     = 2;
  localparam logic [15:0] lfsr_seed_lp       = 16'd65;
  localparam int          writes_per_tile_lp = 8;
  localparam int          add_count_lp       = 10;
  localparam int          burst_len_lp       = 14;
  localparam int          status_rounds_lp   = 4;

  logic                          clk_main_a0;
  logic                          rst_main_n_sync;
  logic                          host_req_v_i;
  mc_op_e                        host_req_op_i;
  logic [tile_id_width_lp-1:0]   host_req_tile_i;
  logic [dmem_addr_width_lp-1:0] host_req_addr_i;
  logic [data_width_lp-1:0]      host_req_data_i;
  logic                          host_resp_v_o;
  logic [tile_id_width_lp-1:0]   host_resp_tile_o;
  logic [data_width_lp-1:0]      host_resp_data_o;
  logic [status_width_lp-1:0]    vdip_i;
  logic [status_width_lp-1:0]    vdip_o;
  logic [status_width_lp-1:0]    vled_o;

  manycore_top i_manycore_top (
    .clk_main_a0      (clk_main_a0),
    .rst_main_n_sync  (rst_main_n_sync),
    .host_req_v_i     (host_req_v_i),
    .host_req_op_i    (host_req_op_i),
    .host_req_tile_i  (host_req_tile_i),
    .host_req_addr_i  (host_req_addr_i),
    .host_req_data_i  (host_req_data_i),
    .host_resp_v_o    (host_resp_v_o),
    .host_resp_tile_o (host_resp_tile_o),
    .host_resp_data_o (host_resp_data_o),
    .vdip_i           (vdip_i),
    .vdip_o           (vdip_o),
    .vled_o           (vled_o)
  );

  `include "tb_tasks.svh"

  initial begin
    clk_main_a0 = 1'b0;
    forever #(clk_period_lp / 2) clk_main_a0 = ~clk_main_a0;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    rst_main_n_sync = 1'b0;
    host_req_v_i    = 1'b0;
    host_req_op_i   = MC_OP_WRITE;
    host_req_tile_i = '0;
    host_req_addr_i = '0;
    host_req_data_i = '0;
    vdip_i          = '0;

    check_reset_state();
    write_read_all_tiles();
    accumulate_adds();
    read_burst();
    dip_passthrough();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- sim.f
+incdir+tests
design/manycore_pkg.sv
design/host_link.sv
design/mc_tile.sv
design/resp_collector.sv
design/status_regs.sv
design/manycore_top.sv
tests/tb_manycore_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_manycore_top
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
